// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int unsigned xlen = 32;

    // base opcodes that change control flow
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // link registers per the calling convention
    localparam logic [4:0] reg_ra = 5'd1;
    localparam logic [4:0] reg_t0 = 5'd5;   // alternate link

    // I-type layout, also covers the jalr fields
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } itype_t;

    // control class seen by the predictor
    typedef enum logic [2:0] {
        ctrl_none,
        ctrl_branch,
        ctrl_jal,
        ctrl_call_jalr,
        ctrl_ret
    } ctrl_class_e;

endpackage

// ==== rtl/bpu_pkg.sv ====
package bpu_pkg;

    // predictor geometry
    localparam int unsigned ghist_w     = 16;
    localparam int unsigned bim_entries = 512;
    localparam int unsigned tag_entries = 256;  // same for t0 and t1
    localparam int unsigned tag_w       = 10;
    localparam int unsigned ptag_bits   = 6;    // compared bits of the tag
    localparam int unsigned btb_entries = 256;
    localparam int unsigned btb_tag_w   = 22;
    localparam int unsigned ras_depth   = 64;
    localparam int unsigned ras_ptr_w   = 7;    // holds 0..ras_depth

    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_strong_nt = 2'b00;
    localparam ctr_t ctr_weak_nt   = 2'b01;
    localparam ctr_t ctr_weak_t    = 2'b10;
    localparam ctr_t ctr_strong_t  = 2'b11;

    typedef logic [ghist_w-1:0] ghist_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        ctr_t             ctr;
    } tage_entry_t;

    typedef struct packed {
        logic                          valid;
        logic [btb_tag_w-1:0]          tag;
        logic [rv_isa_pkg::xlen-1:0]   target;
    } btb_entry_t;

    typedef enum logic [1:0] {
        prov_bim,
        prov_t0,
        prov_t1
    } provider_e;

    typedef struct packed {
        logic [rv_isa_pkg::xlen-1:0] pc;
        logic [rv_isa_pkg::xlen-1:0] inst;
    } fetch_t;

    // branch outcome from execute
    typedef struct packed {
        logic                        valid;     // one-cycle strobe
        logic                        taken;
        logic                        pdt_true;  // prediction was right
        logic [rv_isa_pkg::xlen-1:0] pc;
        ghist_t                      history;   // history seen at predict time
        logic [rv_isa_pkg::xlen-1:0] target;
    } resolve_t;

    typedef struct packed {
        logic                        valid;
        logic [rv_isa_pkg::xlen-1:0] addr;
    } push_t;

    typedef struct packed {
        logic                        is_ctrl;
        logic                        taken;
        logic [rv_isa_pkg::xlen-1:0] target;
        logic [rv_isa_pkg::xlen-1:0] tag_pc;
    } pred_t;

endpackage

// ==== rtl/inst_classify.sv ====
`timescale 1ns/1ps

module inst_classify (
    input  logic [rv_isa_pkg::xlen-1:0] inst_i,
    output rv_isa_pkg::ctrl_class_e     class_o,
    output logic [rv_isa_pkg::xlen-1:0] offset_o
);

    import rv_isa_pkg::*;

    itype_t          f;
    logic [xlen-1:0] b_off;
    logic [xlen-1:0] j_off;
    logic            link_rs1;
    logic            is_ret;

    assign f = itype_t'(inst_i);

    // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign b_off = {{(xlen-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    // J-type: imm[20|10:1|11|19:12]
    assign j_off = {{(xlen-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    assign link_rs1 = (f.rs1 == reg_ra) || (f.rs1 == reg_t0);

    // jalr x0, 0(ra) or 0(t0)
    assign is_ret = (f.rd == 5'd0) && link_rs1 && (f.imm == 12'd0);

    always_comb begin
        class_o  = ctrl_none;
        offset_o = '0;
        case (f.opcode)
            op_branch: begin
                class_o  = ctrl_branch;
                offset_o = b_off;
            end
            op_jal: begin
                class_o  = ctrl_jal;
                offset_o = j_off;
            end
            op_jalr: begin
                // target is register based, no offset here
                class_o = is_ret ? ctrl_ret : ctrl_call_jalr;
            end
            default: begin
                class_o = ctrl_none;
            end
        endcase
    end

endmodule

// ==== rtl/pred_table.sv ====
`timescale 1ns/1ps

module pred_table #(
    parameter type         entry_t   = logic,
    parameter int unsigned entries   = 256,
    parameter entry_t      reset_val = '0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [$clog2(entries)-1:0] rd_idx_i,    // predict side
    input  logic [$clog2(entries)-1:0] upd_idx_i,   // update read and write
    input  logic                       we_i,
    input  entry_t                     wr_data_i,
    output entry_t                     rd_data_o,
    output entry_t                     upd_data_o
);

    entry_t mem [entries];

    // both reads are combinational
    assign rd_data_o  = mem[rd_idx_i];
    assign upd_data_o = mem[upd_idx_i];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                mem[i] <= reset_val;
            end
        end else if (we_i) begin
            mem[upd_idx_i] <= wr_data_i;
        end
    end

endmodule

// ==== rtl/tage_dir.sv ====
`timescale 1ns/1ps

module tage_dir #(
    parameter int unsigned bim_entries = bpu_pkg::bim_entries,
    parameter int unsigned tag_entries = bpu_pkg::tag_entries
) (
    input  logic               clk,
    input  logic               rst,
    input  bpu_pkg::fetch_t    fetch_i,
    input  bpu_pkg::ghist_t    history_i,
    input  bpu_pkg::resolve_t  resolve_i,
    output logic               taken_o,
    output bpu_pkg::provider_e provider_o
);

    import rv_isa_pkg::*;
    import bpu_pkg::*;

    localparam int unsigned tidx_w = $clog2(tag_entries);
    localparam int unsigned bidx_w = $clog2(bim_entries);
    localparam tage_entry_t tage_reset = '{tag: '0, ctr: ctr_weak_nt};

    // indices and tags of one lookup
    typedef struct packed {
        logic [tidx_w-1:0] t0_idx;
        logic [tidx_w-1:0] t1_idx;
        logic [tag_w-1:0]  t0_tag;
        logic [tag_w-1:0]  t1_tag;
        logic [bidx_w-1:0] bim_idx;
    } hash_t;

    function automatic hash_t hash(input logic [xlen-1:0] pc, input ghist_t hist);
        hash_t h;
        h.t0_idx  = pc[tidx_w-1:0] ^ hist[tidx_w-1:0];            // short history
        h.t1_idx  = pc[tidx_w-1:0] ^ hist[2*tidx_w-1:tidx_w];     // older bits
        h.t0_tag  = pc[tidx_w+tag_w-1:tidx_w] ^ hist[ghist_w-1:ghist_w-tag_w];
        h.t1_tag  = pc[tidx_w+tag_w-1:tidx_w] ^ tag_w'(hist[tidx_w-1:0]);
        h.bim_idx = pc[bidx_w:1];
        return h;
    endfunction

    function automatic logic ptag_hit(input logic [tag_w-1:0] stored,
                                      input logic [tag_w-1:0] want);
        return stored[tag_w-1 -: ptag_bits] == want[tag_w-1 -: ptag_bits];
    endfunction

    // longest matching history wins
    function automatic provider_e pick(input logic t0_hit, input logic t1_hit);
        if (t1_hit) return prov_t1;
        if (t0_hit) return prov_t0;
        return prov_bim;
    endfunction

    function automatic ctr_t sat_ctr(input ctr_t c, input logic up);
        if (up) return (c == ctr_strong_t) ? c : c + 2'd1;
        return (c == ctr_strong_nt) ? c : c - 2'd1;
    endfunction

    hash_t       hp;        // fetch side
    hash_t       hu;        // execute side
    tage_entry_t t0_rd, t0_upd, t0_wr;
    tage_entry_t t1_rd, t1_upd, t1_wr;
    logic        t0_we, t1_we;
    provider_e   prov_p, prov_u;
    ctr_t        bim [bim_entries];

    assign hp = hash(fetch_i.pc, history_i);
    assign hu = hash(resolve_i.pc, resolve_i.history);

    pred_table #(
        .entry_t   (tage_entry_t),
        .entries   (tag_entries),
        .reset_val (tage_reset)
    ) u_t0 (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (hp.t0_idx),
        .upd_idx_i  (hu.t0_idx),
        .we_i       (t0_we),
        .wr_data_i  (t0_wr),
        .rd_data_o  (t0_rd),
        .upd_data_o (t0_upd)
    );

    pred_table #(
        .entry_t   (tage_entry_t),
        .entries   (tag_entries),
        .reset_val (tage_reset)
    ) u_t1 (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (hp.t1_idx),
        .upd_idx_i  (hu.t1_idx),
        .we_i       (t1_we),
        .wr_data_i  (t1_wr),
        .rd_data_o  (t1_rd),
        .upd_data_o (t1_upd)
    );

    assign prov_p = pick(ptag_hit(t0_rd.tag, hp.t0_tag), ptag_hit(t1_rd.tag, hp.t1_tag));
    // provider recomputed from the execute pc and history
    assign prov_u = pick(ptag_hit(t0_upd.tag, hu.t0_tag), ptag_hit(t1_upd.tag, hu.t1_tag));

    assign provider_o = prov_p;

    always_comb begin
        case (prov_p)
            prov_t1: taken_o = t1_rd.ctr[1];
            prov_t0: taken_o = t0_rd.ctr[1];
            default: taken_o = bim[hp.bim_idx][1];
        endcase
    end

    always_comb begin
        t0_we = 1'b0;
        t1_we = 1'b0;
        t0_wr = t0_upd;
        t1_wr = t1_upd;
        if (resolve_i.valid) begin
            if (!resolve_i.pdt_true) begin
                case (prov_u)
                    prov_t1: begin
                        t1_we     = 1'b1;
                        t1_wr.ctr = resolve_i.taken ? ctr_strong_t : ctr_strong_nt;
                    end
                    prov_t0: begin
                        t0_we     = 1'b1;
                        t0_wr.ctr = resolve_i.taken ? ctr_strong_t : ctr_strong_nt;
                    end
                    default: begin
                        // bimodal missed, allocate on full tag mismatch
                        if (t1_upd.tag != hu.t1_tag) begin
                            t1_we     = 1'b1;
                            t1_wr.tag = hu.t1_tag;
                            t1_wr.ctr = resolve_i.taken ? ctr_weak_t : ctr_weak_nt;
                        end else if (t0_upd.tag != hu.t0_tag) begin
                            t0_we     = 1'b1;
                            t0_wr.tag = hu.t0_tag;
                            t0_wr.ctr = resolve_i.taken ? ctr_weak_t : ctr_weak_nt;
                        end
                    end
                endcase
            end else if (prov_u == prov_t1) begin
                t1_we     = 1'b1;
                t1_wr.ctr = sat_ctr(t1_upd.ctr, resolve_i.taken);
            end else if (prov_u == prov_t0) begin
                t0_we     = 1'b1;
                t0_wr.ctr = sat_ctr(t0_upd.ctr, resolve_i.taken);
            end
        end
    end

    // bimodal base trains on every resolve
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bim_entries; i++) begin
                bim[i] <= ctr_weak_nt;
            end
        end else if (resolve_i.valid) begin
            bim[hu.bim_idx] <= sat_ctr(bim[hu.bim_idx], resolve_i.taken);
        end
    end

endmodule

// ==== rtl/ras.sv ====
`timescale 1ns/1ps

module ras #(
    parameter int unsigned depth = bpu_pkg::ras_depth
) (
    input  logic                        clk,
    input  logic                        rst,
    input  bpu_pkg::push_t              push_i,      // from decode
    input  logic                        pop_i,       // resolved return
    input  logic                        id_stall_i,
    input  logic                        ex_stall_i,
    output logic [rv_isa_pkg::xlen-1:0] top_o,
    output logic                        empty_o
);

    import rv_isa_pkg::*;
    import bpu_pkg::*;

    localparam int unsigned         slot_w   = $clog2(depth);
    localparam logic [ras_ptr_w-1:0] full_cnt = ras_ptr_w'(depth);

    logic [xlen-1:0]      stack [depth];
    logic [ras_ptr_w-1:0] sp;          // next free slot
    logic [ras_ptr_w-1:0] sp_top;
    logic [ras_ptr_w-1:0] sp_pop;      // pointer after the pop
    logic                 do_pop;
    logic                 do_push;

    assign empty_o = (sp == '0);
    assign sp_top  = sp - 1'b1;
    assign top_o   = stack[sp_top[slot_w-1:0]];   // only meaningful when not empty

    assign do_pop = pop_i && !ex_stall_i;
    assign sp_pop = do_pop ? sp_top : sp;

    // push lands at the slot freed by a same-cycle pop; dropped when full
    assign do_push = push_i.valid && !ex_stall_i && !id_stall_i && (sp_pop < full_cnt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= '0;
        end else begin
            sp <= sp_pop + ras_ptr_w'(do_push);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack[sp_pop[slot_w-1:0]] <= push_i.addr;
        end
    end

endmodule

// ==== rtl/bpu_top.sv ====
`timescale 1ns/1ps

module bpu_top #(
    parameter int unsigned ras_depth   = bpu_pkg::ras_depth,
    parameter int unsigned bim_entries = bpu_pkg::bim_entries,
    parameter int unsigned tag_entries = bpu_pkg::tag_entries,
    parameter int unsigned btb_entries = bpu_pkg::btb_entries
) (
    input  logic                        clk,
    input  logic                        rst,
    input  bpu_pkg::fetch_t             fetch_i,
    input  bpu_pkg::resolve_t           resolve_i,
    input  logic [rv_isa_pkg::xlen-1:0] ex_inst_i,
    input  bpu_pkg::push_t              push_i,
    input  logic                        ex_stall_i,
    input  logic                        id_stall_i,
    input  logic                        flush_i,
    output bpu_pkg::pred_t              pred_o,
    output bpu_pkg::ghist_t             history_o
);

    import rv_isa_pkg::*;
    import bpu_pkg::*;

    localparam int unsigned btb_idx_w = $clog2(btb_entries);

    ctrl_class_e     fetch_class;
    ctrl_class_e     ex_class;
    logic [xlen-1:0] fetch_off;
    ghist_t          ghist;
    logic            dir_taken;
    btb_entry_t      btb_rd;
    btb_entry_t      btb_wr;
    logic            btb_hit;
    logic [xlen-1:0] ras_top;
    logic            ras_empty;
    logic            ras_pop;
    logic            push_fire;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] jump_tgt;

    inst_classify u_fetch_cls (
        .inst_i   (fetch_i.inst),
        .class_o  (fetch_class),
        .offset_o (fetch_off)
    );

    // execute copy, only the return class matters
    inst_classify u_ex_cls (
        .inst_i   (ex_inst_i),
        .class_o  (ex_class),
        .offset_o ()
    );

    tage_dir #(
        .bim_entries (bim_entries),
        .tag_entries (tag_entries)
    ) u_dir (
        .clk        (clk),
        .rst        (rst),
        .fetch_i    (fetch_i),
        .history_i  (ghist),
        .resolve_i  (resolve_i),
        .taken_o    (dir_taken),
        .provider_o ()
    );

    // btb learns every taken resolve
    assign btb_wr.valid  = 1'b1;
    assign btb_wr.tag    = resolve_i.pc[xlen-1 -: btb_tag_w];
    assign btb_wr.target = resolve_i.target;

    pred_table #(
        .entry_t   (btb_entry_t),
        .entries   (btb_entries),
        .reset_val (btb_entry_t'('0))
    ) u_btb (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (fetch_i.pc[btb_idx_w+1:2]),
        .upd_idx_i  (resolve_i.pc[btb_idx_w+1:2]),
        .we_i       (resolve_i.valid && resolve_i.taken),
        .wr_data_i  (btb_wr),
        .rd_data_o  (btb_rd),
        .upd_data_o ()
    );

    assign btb_hit = btb_rd.valid && (btb_rd.tag == fetch_i.pc[xlen-1 -: btb_tag_w]);

    assign ras_pop   = resolve_i.valid && resolve_i.taken && (ex_class == ctrl_ret) && !ras_empty;
    assign push_fire = push_i.valid && !ex_stall_i && !id_stall_i;

    ras #(
        .depth (ras_depth)
    ) u_ras (
        .clk        (clk),
        .rst        (rst),
        .push_i     (push_i),
        .pop_i      (ras_pop),
        .id_stall_i (id_stall_i),
        .ex_stall_i (ex_stall_i),
        .top_o      (ras_top),
        .empty_o    (ras_empty)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
        end else if (resolve_i.valid) begin
            ghist <= {ghist[ghist_w-2:0], resolve_i.taken};
        end
    end

    assign history_o = ghist;

    assign pc_plus4 = fetch_i.pc + xlen'(4);
    assign jump_tgt = btb_hit ? btb_rd.target : fetch_i.pc + fetch_off;

    always_comb begin
        pred_o.is_ctrl = 1'b0;
        pred_o.taken   = 1'b0;
        pred_o.target  = pc_plus4;
        if (!flush_i) begin     // flushed slot behaves like a plain instruction
            case (fetch_class)
                ctrl_ret: begin
                    pred_o.is_ctrl = 1'b1;
                    if (push_fire) begin
                        pred_o.taken  = 1'b1;
                        pred_o.target = push_i.addr;   // call still in decode
                    end else if (!ras_empty) begin
                        pred_o.taken  = 1'b1;
                        pred_o.target = ras_top;
                    end
                end
                ctrl_jal: begin
                    pred_o.is_ctrl = 1'b1;
                    pred_o.taken   = 1'b1;
                    pred_o.target  = jump_tgt;
                end
                ctrl_branch: begin
                    pred_o.is_ctrl = 1'b1;
                    pred_o.taken   = dir_taken;
                    if (dir_taken) begin
                        pred_o.target = jump_tgt;
                    end
                end
                ctrl_call_jalr: begin
                    pred_o.is_ctrl = 1'b1;
                    if (btb_hit) begin
                        pred_o.taken  = 1'b1;
                        pred_o.target = btb_rd.target;
                    end
                end
                default: begin
                    pred_o.is_ctrl = 1'b0;
                end
            endcase
        end
        pred_o.tag_pc = pred_o.taken ? fetch_i.pc : '0;
    end

endmodule

// ==== test/bpu_sva.sv ====
`timescale 1ns/1ps

module bpu_sva (
    input logic            clk,
    input logic            rst,
    input bpu_pkg::fetch_t fetch_i,
    input bpu_pkg::pred_t  pred_i,
    input logic            pop_i,
    input logic            empty_i
);

    taken_needs_ctrl: assert property (@(posedge clk) disable iff (rst)
        pred_i.taken |-> pred_i.is_ctrl)
        else $error("taken prediction for a non-control instruction");

    // plain instructions fall through
    plain_falls_through: assert property (@(posedge clk) disable iff (rst)
        !pred_i.is_ctrl |-> (!pred_i.taken && pred_i.target == fetch_i.pc + 32'd4))
        else $error("non-control instruction did not predict pc+4");

    // the stack only drains through a resolved return
    empty_after_pop: assert property (@(posedge clk) disable iff (rst)
        $rose(empty_i) |-> $past(pop_i))
        else $error("ras became empty without a pop");

endmodule

bind bpu_top bpu_sva u_sva (
    .clk     (clk),
    .rst     (rst),
    .fetch_i (fetch_i),
    .pred_i  (pred_o),
    .pop_i   (ras_pop),
    .empty_i (ras_empty)
);

// ==== test/bpu_tb.sv ====
`timescale 1ns/1ps

module bpu_tb;

    import bpu_pkg::*;

    localparam int unsigned clk_period = 40;
    localparam int          max_steps  = 64;

    localparam logic [31:0] nop_inst = 32'h0000_0013;   // addi x0, x0, 0
    localparam logic [31:0] ret_inst = 32'h0000_8067;   // jalr x0, 0(ra)
    localparam logic [31:0] beq_inst = 32'h0020_8863;   // beq x1, x2, +16
    localparam logic [31:0] jal_inst = 32'h1000_00ef;   // jal ra, +0x100

    localparam logic [31:0] nop_pc  = 32'h0000_5000;
    localparam logic [31:0] ret_pc  = 32'h0000_4000;
    localparam logic [31:0] jal_pc  = 32'h0000_2000;
    localparam logic [31:0] jal_btb = 32'h0000_3000;
    // pc[17:12] keeps the hashed tags clear of the zero reset tags
    localparam logic [31:0] br_pc   = 32'h0002_a100;
    localparam logic [31:0] br_tgt  = 32'h0002_a140;
    localparam logic [31:0] ra_a    = 32'h0000_1104;
    localparam logic [31:0] ra_b    = 32'h0000_2204;
    localparam logic [31:0] ra_c    = 32'h0000_3304;
    localparam logic [31:0] ra_d    = 32'h0000_4404;
    localparam logic [31:0] ra_e    = 32'h0000_5504;
    localparam logic [31:0] ra_f    = 32'h0000_6604;

    // one row of the stimulus table
    typedef struct packed {
        fetch_t      fetch;
        logic        res_valid;
        logic        res_taken;
        logic [31:0] res_pc;
        logic [31:0] res_target;
        logic [31:0] ex_inst;
        push_t       push;
        logic        id_stall;
        logic        ex_stall;
        logic        exp_ctrl;
        logic        exp_taken;
        logic [31:0] exp_target;
    } step_t;

    logic        clk;
    logic        rst;
    fetch_t      fetch;
    resolve_t    resolve;
    logic [31:0] ex_inst;
    push_t       push;
    logic        ex_stall;
    logic        id_stall;
    logic        flush;
    pred_t       pred;
    ghist_t      history;

    step_t       steps [max_steps];
    string       names [max_steps];
    int          n_steps;
    int          errors;
    int          failed_steps;
    int          cycles      = 0;
    int          cycle_limit = 0;
    logic        step_bad;
    ghist_t      exp_hist;      // taken bits shifted in by the bench

    bpu_top #(
        .ras_depth   (ras_depth),
        .bim_entries (bim_entries),
        .tag_entries (tag_entries),
        .btb_entries (btb_entries)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .fetch_i    (fetch),
        .resolve_i  (resolve),
        .ex_inst_i  (ex_inst),
        .push_i     (push),
        .ex_stall_i (ex_stall),
        .id_stall_i (id_stall),
        .flush_i    (flush),
        .pred_o     (pred),
        .history_o  (history)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // new row that fetches one instruction with all other inputs idle
    task automatic add_fetch(input string name, input logic [31:0] pc, input logic [31:0] inst,
                             input logic ctrl, input logic taken, input logic [31:0] target);
        step_t s;
        s            = '0;
        s.fetch.pc   = pc;
        s.fetch.inst = inst;
        s.exp_ctrl   = ctrl;
        s.exp_taken  = taken;
        s.exp_target = target;
        steps[n_steps] = s;
        names[n_steps] = name;
        n_steps++;
    endtask

    task automatic with_resolve(input logic [31:0] pc, input logic [31:0] inst,
                                input logic [31:0] target);
        steps[n_steps-1].res_valid  = 1'b1;
        steps[n_steps-1].res_taken  = 1'b1;
        steps[n_steps-1].res_pc     = pc;
        steps[n_steps-1].ex_inst    = inst;
        steps[n_steps-1].res_target = target;
    endtask

    task automatic with_push(input logic [31:0] addr, input logic id_st, input logic ex_st);
        steps[n_steps-1].push.valid = 1'b1;
        steps[n_steps-1].push.addr  = addr;
        steps[n_steps-1].id_stall   = id_st;
        steps[n_steps-1].ex_stall   = ex_st;
    endtask

    task automatic build_steps();
        logic [31:0] r_pc;
        logic [31:0] r_inst;
        for (int k = 0; k < 6; k++) begin
            r_pc        = $urandom() & 32'hffff_fffc;
            r_inst      = $urandom();
            r_inst[6:0] = (k % 2 == 0) ? 7'h13 : 7'h33;   // op-imm or op
            add_fetch($sformatf("plain_%0d", k), r_pc, r_inst, 1'b0, 1'b0, r_pc + 32'd4);
        end
        // first taken resolve makes the bimodal counter weak taken and allocates t1 taken
        add_fetch("br_fresh", br_pc, beq_inst, 1'b1, 1'b0, br_pc + 32'd4);
        with_resolve(br_pc, beq_inst, br_tgt);
        for (int k = 1; k < 18; k++) begin
            add_fetch($sformatf("br_train_%0d", k), br_pc, beq_inst, 1'b1, 1'b1, br_tgt);
            with_resolve(br_pc, beq_inst, br_tgt);
        end
        add_fetch("br_trained", br_pc, beq_inst, 1'b1, 1'b1, br_tgt);
        add_fetch("jal_offset", jal_pc, jal_inst, 1'b1, 1'b1, jal_pc + 32'h100);
        with_resolve(jal_pc, jal_inst, jal_btb);
        add_fetch("jal_btb", jal_pc, jal_inst, 1'b1, 1'b1, jal_btb);
        add_fetch("push_a", nop_pc, nop_inst, 1'b0, 1'b0, nop_pc + 32'd4);
        with_push(ra_a, 1'b0, 1'b0);
        add_fetch("push_b", nop_pc + 32'd4, nop_inst, 1'b0, 1'b0, nop_pc + 32'd8);
        with_push(ra_b, 1'b0, 1'b0);
        add_fetch("ret_b", ret_pc, ret_inst, 1'b1, 1'b1, ra_b);
        add_fetch("pop_b", ret_pc, ret_inst, 1'b1, 1'b1, ra_b);
        with_resolve(ret_pc, ret_inst, ra_b);
        add_fetch("ret_a", ret_pc, ret_inst, 1'b1, 1'b1, ra_a);
        with_resolve(ret_pc, ret_inst, ra_a);
        add_fetch("ret_empty", ret_pc, ret_inst, 1'b1, 1'b0, ret_pc + 32'd4);
        add_fetch("push_id_stall", nop_pc, nop_inst, 1'b0, 1'b0, nop_pc + 32'd4);
        with_push(ra_c, 1'b1, 1'b0);
        add_fetch("ret_still_empty", ret_pc, ret_inst, 1'b1, 1'b0, ret_pc + 32'd4);
        add_fetch("push_d", nop_pc, nop_inst, 1'b0, 1'b0, nop_pc + 32'd4);
        with_push(ra_d, 1'b0, 1'b0);
        add_fetch("push_ex_stall", nop_pc, nop_inst, 1'b0, 1'b0, nop_pc + 32'd4);
        with_push(ra_e, 1'b0, 1'b1);
        add_fetch("ret_d", ret_pc, ret_inst, 1'b1, 1'b1, ra_d);
        add_fetch("ret_with_push", ret_pc, ret_inst, 1'b1, 1'b1, ra_f);
        with_push(ra_f, 1'b0, 1'b0);
        add_fetch("ret_after_push", ret_pc, ret_inst, 1'b1, 1'b1, ra_f);
    endtask

    task automatic apply(input step_t s);
        resolve_t r;
        r.valid    = s.res_valid;
        r.taken    = s.res_taken;
        r.pdt_true = (s.exp_taken == s.res_taken);
        r.pc       = s.res_pc;
        r.history  = exp_hist;     // history seen by the fetch of this row
        r.target   = s.res_target;
        fetch    <= s.fetch;
        resolve  <= r;
        ex_inst  <= s.ex_inst;
        push     <= s.push;
        id_stall <= s.id_stall;
        ex_stall <= s.ex_stall;
    endtask

    task automatic compare(input string name, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %h, actual %h", name, what, expected, actual);
            errors++;
            step_bad = 1'b1;
        end
    endtask

    initial begin
        rst      <= 1'b1;
        fetch    <= '0;
        resolve  <= '0;
        ex_inst  <= '0;
        push     <= '0;
        ex_stall <= 1'b0;
        id_stall <= 1'b0;
        flush    <= 1'b0;
        n_steps      = 0;
        errors       = 0;
        failed_steps = 0;
        exp_hist     = '0;
        void'($urandom(32'h90b3));
        build_steps();
        cycle_limit = n_steps * 2 + 50;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_steps; i++) begin
            @(posedge clk);
            apply(steps[i]);
            #(clk_period - 5);    // sample just before the next edge
            step_bad = 1'b0;
            compare(names[i], "is_ctrl", 32'(steps[i].exp_ctrl), 32'(pred.is_ctrl));
            compare(names[i], "taken", 32'(steps[i].exp_taken), 32'(pred.taken));
            compare(names[i], "target", steps[i].exp_target, pred.target);
            if (steps[i].exp_taken) begin
                compare(names[i], "tag_pc", steps[i].fetch.pc, pred.tag_pc);
            end
            compare(names[i], "history", 32'(exp_hist), 32'(history));
            if (steps[i].res_valid) begin
                exp_hist = {exp_hist[ghist_w-2:0], steps[i].res_taken};
            end
            if (step_bad) begin
                failed_steps++;
            end
            $display("%s: %s", names[i], step_bad ? "mismatch" : "ok");
        end
        $display("%0d steps, %0d failed, %0d errors", n_steps, failed_steps, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== bpu.f ====
rtl/rv_isa_pkg.sv
rtl/bpu_pkg.sv
rtl/inst_classify.sv
rtl/pred_table.sv
rtl/tage_dir.sv
rtl/ras.sv
rtl/bpu_top.sv
test/bpu_sva.sv
test/bpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bpu_tb
FILELIST  ?= bpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
